//--- compute_core.f
design/gpu_core_pkg.sv
design/credit_tx.sv
design/fetch_arbiter.sv
design/warp_context.sv
design/warp_scheduler.sv
design/simd_lane.sv
design/compute_core.sv
verif/tb_compute_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f compute_core.f --top-module tb_compute_core
sim_out=$(./obj_dir/Vtb_compute_core)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q "Simulation completed successfully"; then
    exit 0
else
    exit 1
fi

//--- verif/tb_compute_core.sv
`timescale 1ns/100ps

module tb_compute_core
    import gpu_core_pkg::*;
();

    // Longest program runs about 40 instructions per warp
    localparam int TIMEOUT_CYCLES = WARPS * 40 * 12 + 200;
    localparam int PC_MASK = (1 << PC_W) - 1;

    logic        clk;
    logic        reset;
    logic        start;
    logic        done;
    logic        ifetch_valid;
    ifetch_req_t ifetch_req;
    logic        ifetch_credit;
    logic        ifetch_rsp_valid;
    ifetch_rsp_t ifetch_rsp;
    logic        result_valid;
    result_t     result;
    logic        result_credit;

    logic [31:0]          lfsr_state = 32'h931d;
    logic [INSTR_W-1:0]   imem [WARPS << PC_W];
    addr_t                exp_fetch [WARPS][64];
    result_t              exp_res [WARPS][40];
    int                   fetch_n [WARPS];
    int                   fetch_rd [WARPS];
    int                   res_n [WARPS];
    int                   res_rd [WARPS];
    ifetch_req_t          fetch_q [$];
    int                   fetch_due_q [$];
    int                   credit_due_q [$];
    int                   res_out = 0;
    int                   cycles = 0;
    int                   mismatches = 0;
    int                   failures = 0;
    logic                 started;
    logic                 done_prev = 1'b0;
    warp_idx_t            fw;
    warp_idx_t            rw;

    compute_core u_compute_core (
        .clk              (clk),
        .reset            (reset),
        .start            (start),
        .done             (done),
        .ifetch_valid     (ifetch_valid),
        .ifetch_req       (ifetch_req),
        .ifetch_credit    (ifetch_credit),
        .ifetch_rsp_valid (ifetch_rsp_valid),
        .ifetch_rsp       (ifetch_rsp),
        .result_valid     (result_valid),
        .result           (result),
        .result_credit    (result_credit)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("[ERROR] %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        failures++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic build_program(input int w);
        int               n;
        int               base;
        int               cnt;
        logic [2:0]       kind;
        logic [2:0]       rd;
        logic [2:0]       rs1;
        logic [2:0]       rs2;
        logic [5:0]       imm;
        opcode_t          op;
        base = w << PC_W;
        n = 10 + int'(random_bits(4));
        for (int i = 0; i < n; i++) begin
            kind = 3'(random_bits(3));
            rd = 3'(random_bits(3));
            rs1 = 3'(random_bits(3));
            rs2 = 3'(random_bits(3));
            imm = 6'(random_bits(6));
            case (kind)
                3'd0: op = OP_ADD;
                3'd1: op = OP_SUB;
                3'd2: op = OP_AND;
                3'd3: op = OP_XOR;
                3'd4: op = OP_ADDI;
                3'd5: op = OP_TID;
                default: op = OP_STORE;
            endcase
            if (op == OP_ADDI) begin
                imem[base + i] = {op, rd, rs1, imm};
            end else if (op == OP_STORE) begin
                imem[base + i] = {op, 3'd0, rs1, 6'd0};
            end else begin
                imem[base + i] = {op, rd, rs1, rs2, 3'd0};
            end
        end
        // Counted loop on r7 whose body stores r7 and counts it down
        cnt = int'(random_bits(2)) % 3 + 1;
        imem[base + n] = {OP_XOR, 3'd7, 3'd7, 3'd7, 3'd0};
        imem[base + n + 1] = {OP_ADDI, 3'd7, 3'd7, 6'(cnt)};
        imem[base + n + 2] = {OP_STORE, 3'd0, 3'd7, 6'd0};
        imem[base + n + 3] = {OP_ADDI, 3'd7, 3'd7, 6'h3f};
        imem[base + n + 4] = {OP_BNZ, 3'd0, 3'd7, 6'h3e};
        imem[base + n + 5] = {OP_HALT, 12'd0};
    endtask

    // Sequential execution of one warp's program
    task automatic run_model(input int w);
        data_t              mregs [REGS][LANES];
        int                 pc;
        logic [INSTR_W-1:0] word;
        instr_t             ins;
        data_t              imm;
        data_t              a;
        data_t              b;
        result_t            rec;
        foreach (mregs[r, l]) begin
            mregs[r][l] = '0;
        end
        pc = 0;
        fetch_n[w] = 0;
        res_n[w] = 0;
        for (int step = 0; step < 64; step++) begin
            exp_fetch[w][fetch_n[w]] = addr_t'((w << PC_W) + pc);
            fetch_n[w]++;
            word = imem[(w << PC_W) + pc];
            ins = instr_t'(word);
            imm = {{(DATA_W-6){word[5]}}, word[5:0]};
            if (ins.opcode == OP_HALT) begin
                break;
            end
            if (ins.opcode == OP_STORE) begin
                rec.warp = warp_idx_t'(w);
                rec.src = ins.rs1;
                for (int l = 0; l < LANES; l++) begin
                    rec.data[l] = mregs[ins.rs1][l];
                end
                exp_res[w][res_n[w]] = rec;
                res_n[w]++;
            end
            if (ins.opcode == OP_BNZ && mregs[ins.rs1][0] != '0) begin
                pc = (pc + int'($signed(word[5:0]))) & PC_MASK;
            end else begin
                pc = (pc + 1) & PC_MASK;
            end
            for (int l = 0; l < LANES; l++) begin
                a = mregs[ins.rs1][l];
                b = mregs[ins.rs2][l];
                case (ins.opcode)
                    OP_ADD:  mregs[ins.rd][l] = a + b;
                    OP_SUB:  mregs[ins.rd][l] = a - b;
                    OP_AND:  mregs[ins.rd][l] = a & b;
                    OP_XOR:  mregs[ins.rd][l] = a ^ b;
                    OP_ADDI: mregs[ins.rd][l] = a + imm;
                    OP_TID:  mregs[ins.rd][l] = data_t'(w * LANES + l);
                    default: ;
                endcase
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run hung: done did not rise within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks done: %0d value mismatches, %0d other failures",
                     mismatches, failures);
            $display("Simulation failed");
            $finish;
        end
    end

    // Instruction memory, result sink and output checks
    always @(posedge clk) begin
        ifetch_rsp_valid <= 1'b0;
        ifetch_credit <= 1'b0;
        result_credit <= 1'b0;
        if (!reset) begin
            if (!started) begin
                check_equal("ifetch_valid before start", ifetch_valid, 0);
                check_equal("result_valid before start", result_valid, 0);
                check_equal("done before start", done, 0);
            end
            if (ifetch_valid) begin
                fw = ifetch_req.warp;
                check_equal("fetch tag against address", ifetch_req.addr[ADDR_W-1:PC_W], fw);
                if (fetch_rd[fw] < fetch_n[fw]) begin
                    check_equal($sformatf("warp %0d fetch %0d address", fw, fetch_rd[fw]),
                                ifetch_req.addr, exp_fetch[fw][fetch_rd[fw]]);
                    fetch_rd[fw]++;
                end else begin
                    report_failure($sformatf("warp %0d fetched past its program", fw));
                end
                fetch_q.push_back(ifetch_req);
                fetch_due_q.push_back(cycles + int'(random_bits(3)) % 6);
                if (fetch_q.size() > FETCH_CREDITS) begin
                    report_failure("more fetches outstanding than fetch credits");
                end
            end
            // Answers stay in request order
            if (fetch_q.size() > 0 && cycles >= fetch_due_q[0]) begin
                ifetch_rsp_valid <= 1'b1;
                ifetch_rsp <= '{warp: fetch_q[0].warp, instr: instr_t'(imem[fetch_q[0].addr])};
                ifetch_credit <= 1'b1;
                void'(fetch_q.pop_front());
                void'(fetch_due_q.pop_front());
            end
            if (result_valid) begin
                rw = result.warp;
                if (res_rd[rw] < res_n[rw]) begin
                    check_equal($sformatf("warp %0d result %0d register", rw, res_rd[rw]),
                                result.src, exp_res[rw][res_rd[rw]].src);
                    for (int l = 0; l < LANES; l++) begin
                        check_equal($sformatf("warp %0d result %0d lane %0d", rw, res_rd[rw], l),
                                    result.data[l], exp_res[rw][res_rd[rw]].data[l]);
                    end
                    res_rd[rw]++;
                end else begin
                    report_failure($sformatf("warp %0d sent more results than expected", rw));
                end
                res_out++;
                credit_due_q.push_back(cycles + int'(random_bits(3)));
                if (res_out > RESULT_CREDITS) begin
                    report_failure("more results outstanding than result credits");
                end
            end
            if (credit_due_q.size() > 0 && cycles >= credit_due_q[0]) begin
                result_credit <= 1'b1;
                void'(credit_due_q.pop_front());
                res_out--;
            end
            if (done_prev && !done) begin
                report_failure("done fell without a new start");
            end
            if (done && !done_prev) begin
                for (int w = 0; w < WARPS; w++) begin
                    if (fetch_rd[w] != fetch_n[w] || res_rd[w] != res_n[w]) begin
                        report_failure($sformatf("done rose before warp %0d finished", w));
                    end
                end
            end
            done_prev <= done;
        end
    end

    initial begin
        reset = 1'b1;
        start = 1'b0;
        ifetch_credit = 1'b0;
        ifetch_rsp_valid = 1'b0;
        ifetch_rsp = '0;
        result_credit = 1'b0;
        started = 1'b0;
        for (int a = 0; a < (WARPS << PC_W); a++) begin
            imem[a] = {OP_HALT, 5'd0, addr_t'(a)};
        end
        for (int w = 0; w < WARPS; w++) begin
            fetch_rd[w] = 0;
            res_rd[w] = 0;
            build_program(w);
            run_model(w);
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);
        start <= 1'b1;
        started <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        do @(posedge clk); while (!done);
        // done must hold after completion
        repeat (5) @(posedge clk);
        @(negedge clk);
        $display("Checks done: %0d value mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- design/compute_core.sv
`timescale 1ns/100ps

module compute_core
    import gpu_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    output logic        done,
    output logic        ifetch_valid,
    output ifetch_req_t ifetch_req,
    input  logic        ifetch_credit,
    input  logic        ifetch_rsp_valid,
    input  ifetch_rsp_t ifetch_rsp,
    output logic        result_valid,
    output result_t     result,
    input  logic        result_credit
);

    logic [WARPS-1:0]  fetch_req;
    logic [WARPS-1:0]  fetch_grant;
    logic [WARPS-1:0]  rsp_load;
    logic [WARPS-1:0]  issue;
    logic [WARPS-1:0]  halt;
    addr_t             fetch_addr [WARPS];
    warp_status_t      status [WARPS];
    instr_t            instr [WARPS];
    pc_t               pc [WARPS];
    instr_t            rsp_instr;
    pc_t               next_pc;
    lane_op_t          lane_op;
    data_t [LANES-1:0] lane_rs1;

    fetch_arbiter u_fetch_arbiter (
        .clk              (clk),
        .reset            (reset),
        .fetch_req        (fetch_req),
        .fetch_addr       (fetch_addr),
        .ifetch_credit    (ifetch_credit),
        .ifetch_rsp_valid (ifetch_rsp_valid),
        .ifetch_rsp       (ifetch_rsp),
        .fetch_grant      (fetch_grant),
        .ifetch_valid     (ifetch_valid),
        .ifetch_req       (ifetch_req),
        .rsp_load         (rsp_load),
        .rsp_instr        (rsp_instr)
    );

    for (genvar w = 0; w < WARPS; w++) begin : g_warp
        warp_context #(
            .WARP_ID (w)
        ) u_warp_context (
            .clk         (clk),
            .reset       (reset),
            .start       (start),
            .fetch_grant (fetch_grant[w]),
            .rsp_load    (rsp_load[w]),
            .rsp_instr   (rsp_instr),
            .issue       (issue[w]),
            .next_pc     (next_pc),
            .halt        (halt[w]),
            .fetch_req   (fetch_req[w]),
            .fetch_addr  (fetch_addr[w]),
            .status      (status[w]),
            .instr       (instr[w]),
            .pc          (pc[w])
        );
    end

    warp_scheduler u_warp_scheduler (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .status        (status),
        .instr         (instr),
        .pc            (pc),
        .lane_rs1_data (lane_rs1),
        .result_credit (result_credit),
        .issue         (issue),
        .halt          (halt),
        .next_pc       (next_pc),
        .lane_op       (lane_op),
        .result_valid  (result_valid),
        .result        (result),
        .done          (done)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        simd_lane #(
            .LANE_ID (l)
        ) u_simd_lane (
            .clk      (clk),
            .reset    (reset),
            .lane_op  (lane_op),
            .rs1_data (lane_rs1[l])
        );
    end

endmodule

//--- design/simd_lane.sv
`timescale 1ns/100ps

module simd_lane
    import gpu_core_pkg::*;
#(
    parameter int LANE_ID = 0
) (
    input  logic     clk,
    input  logic     reset,
    input  lane_op_t lane_op,
    output data_t    rs1_data
);

    // One register bank per warp
    data_t regs [WARPS][REGS];
    data_t rs2_data;
    data_t alu_out;

    assign rs1_data = regs[lane_op.warp][lane_op.rs1];
    assign rs2_data = regs[lane_op.warp][lane_op.rs2];

    always_comb begin
        case (lane_op.op)
            OP_ADD:  alu_out = rs1_data + rs2_data;
            OP_SUB:  alu_out = rs1_data - rs2_data;
            OP_AND:  alu_out = rs1_data & rs2_data;
            OP_XOR:  alu_out = rs1_data ^ rs2_data;
            OP_ADDI: alu_out = rs1_data + lane_op.imm;
            // Global thread index
            OP_TID:  alu_out = DATA_W'(lane_op.warp) * DATA_W'(LANES) + DATA_W'(LANE_ID);
            default: alu_out = rs1_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WARPS; w++) begin
                for (int r = 0; r < REGS; r++) begin
                    regs[w][r] <= '0;
                end
            end
        end else if (lane_op.we) begin
            regs[lane_op.warp][lane_op.rd] <= alu_out;
        end
    end

endmodule

//--- design/warp_scheduler.sv
`timescale 1ns/100ps

module warp_scheduler
    import gpu_core_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  warp_status_t        status [WARPS],
    input  instr_t              instr [WARPS],
    input  pc_t                 pc [WARPS],
    input  data_t [LANES-1:0]   lane_rs1_data,
    input  logic                result_credit,
    output logic [WARPS-1:0]    issue,
    output logic [WARPS-1:0]    halt,
    output pc_t                 next_pc,
    output lane_op_t            lane_op,
    output logic                result_valid,
    output result_t             result,
    output logic                done
);

    logic [WARPS-1:0] eligible;
    logic             all_done;
    logic             any;
    logic             res_can_send;
    logic             store_send;
    warp_idx_t        last_issue;
    warp_idx_t        sel;
    instr_t           cur;
    logic [IMM_W-1:0] imm6;
    result_t          store_rec;

    // A STORE waits for a free slot in the result sink
    always_comb begin
        all_done = 1'b1;
        for (int w = 0; w < WARPS; w++) begin
            eligible[w] = (status[w] == WS_READY) &&
                          !(instr[w].opcode == OP_STORE && !res_can_send);
            if (status[w] != WS_DONE) begin
                all_done = 1'b0;
            end
        end
    end

    always_comb begin
        any = 1'b0;
        sel = last_issue;
        for (int i = 1; i <= WARPS; i++) begin
            if (!any && eligible[(int'(last_issue) + i) % WARPS]) begin
                any = 1'b1;
                sel = warp_idx_t'((int'(last_issue) + i) % WARPS);
            end
        end
    end

    assign cur = instr[sel];
    assign imm6 = {cur.rs2, cur.pad};

    always_comb begin
        lane_op.op = cur.opcode;
        lane_op.warp = sel;
        lane_op.rd = cur.rd;
        lane_op.rs1 = cur.rs1;
        lane_op.rs2 = cur.rs2;
        lane_op.imm = {{(DATA_W-IMM_W){imm6[IMM_W-1]}}, imm6};
        case (cur.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI, OP_TID: lane_op.we = any;
            default: lane_op.we = 1'b0;
        endcase
    end

    // Branch decision follows lane 0 only
    always_comb begin
        if (cur.opcode == OP_BNZ && lane_rs1_data[0] != '0) begin
            next_pc = pc[sel] + imm6[PC_W-1:0];
        end else begin
            next_pc = pc[sel] + 1'b1;
        end
    end

    assign issue = (any && cur.opcode != OP_HALT) ? (WARPS'(1) << sel) : '0;
    assign halt = (any && cur.opcode == OP_HALT) ? (WARPS'(1) << sel) : '0;

    assign store_send = any && (cur.opcode == OP_STORE);
    assign store_rec = '{warp: sel, src: cur.rs1, data: lane_rs1_data};

    always_ff @(posedge clk) begin
        if (reset) begin
            last_issue <= '0;
            done <= 1'b0;
        end else begin
            if (any) begin
                last_issue <= sel;
            end
            done <= start ? 1'b0 : all_done;
        end
    end

    credit_tx #(
        .payload_t (result_t),
        .CREDITS   (RESULT_CREDITS)
    ) u_result_tx (
        .clk           (clk),
        .reset         (reset),
        .send          (store_send),
        .payload       (store_rec),
        .credit_return (result_credit),
        .can_send      (res_can_send),
        .tx_valid      (result_valid),
        .tx_payload    (result)
    );

endmodule

//--- design/warp_context.sv
`timescale 1ns/100ps

module warp_context
    import gpu_core_pkg::*;
#(
    parameter int WARP_ID = 0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic         fetch_grant,
    input  logic         rsp_load,
    input  instr_t       rsp_instr,
    input  logic         issue,
    input  pc_t          next_pc,
    input  logic         halt,
    output logic         fetch_req,
    output addr_t        fetch_addr,
    output warp_status_t status,
    output instr_t       instr,
    output pc_t          pc
);

    // Set once the fetch has left, cleared when the instruction returns
    logic requested;

    assign fetch_req = (status == WS_FETCH) && !requested;
    assign fetch_addr = {warp_idx_t'(WARP_ID), pc};

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= WS_IDLE;
            pc <= '0;
            requested <= 1'b0;
        end else if (start) begin
            status <= WS_FETCH;
            pc <= '0;
            requested <= 1'b0;
        end else begin
            case (status)
                WS_FETCH: begin
                    if (rsp_load) begin
                        status <= WS_READY;
                        requested <= 1'b0;
                    end else if (fetch_grant) begin
                        requested <= 1'b1;
                    end
                end
                WS_READY: begin
                    if (halt) begin
                        status <= WS_DONE;
                    end else if (issue) begin
                        // Back to fetching at the address the scheduler resolved
                        pc <= next_pc;
                        status <= WS_FETCH;
                    end
                end
                default: begin
                    status <= status;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_load) begin
            instr <= rsp_instr;
        end
    end

endmodule

//--- design/fetch_arbiter.sv
`timescale 1ns/100ps

module fetch_arbiter
    import gpu_core_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [WARPS-1:0]   fetch_req,
    input  addr_t              fetch_addr [WARPS],
    input  logic               ifetch_credit,
    input  logic               ifetch_rsp_valid,
    input  ifetch_rsp_t        ifetch_rsp,
    output logic [WARPS-1:0]   fetch_grant,
    output logic               ifetch_valid,
    output ifetch_req_t        ifetch_req,
    output logic [WARPS-1:0]   rsp_load,
    output instr_t             rsp_instr
);

    warp_idx_t   last_grant;
    warp_idx_t   pick;
    logic        found;
    logic        can_send;
    ifetch_req_t req_payload;

    // Search starts one past the last granted warp
    always_comb begin
        found = 1'b0;
        pick = last_grant;
        for (int i = 1; i <= WARPS; i++) begin
            if (!found && fetch_req[(int'(last_grant) + i) % WARPS]) begin
                found = 1'b1;
                pick = warp_idx_t'((int'(last_grant) + i) % WARPS);
            end
        end
    end

    assign fetch_grant = (found && can_send) ? (WARPS'(1) << pick) : '0;
    assign req_payload = '{warp: pick, addr: fetch_addr[pick]};

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= '0;
        end else if (found && can_send) begin
            last_grant <= pick;
        end
    end

    credit_tx #(
        .payload_t (ifetch_req_t),
        .CREDITS   (FETCH_CREDITS)
    ) u_fetch_tx (
        .clk           (clk),
        .reset         (reset),
        .send          (found),
        .payload       (req_payload),
        .credit_return (ifetch_credit),
        .can_send      (can_send),
        .tx_valid      (ifetch_valid),
        .tx_payload    (ifetch_req)
    );

    // Tag of the response picks the warp that captures it
    assign rsp_load = ifetch_rsp_valid ? (WARPS'(1) << ifetch_rsp.warp) : '0;
    assign rsp_instr = ifetch_rsp.instr;

endmodule

//--- design/credit_tx.sv
`timescale 1ns/100ps

module credit_tx #(
    parameter type payload_t = logic,
    parameter int CREDITS = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     send,
    input  payload_t payload,
    input  logic     credit_return,
    output logic     can_send,
    output logic     tx_valid,
    output payload_t tx_payload
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credits;
    logic             take;

    assign can_send = (credits != '0);
    assign take = send && can_send;

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CNT_W'(CREDITS);
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= take;
            // A send and a return in the same cycle cancel out
            case ({take, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            tx_payload <= payload;
        end
    end

endmodule

//--- design/gpu_core_pkg.sv
package gpu_core_pkg;

    // Core dimensions
    localparam int WARPS = 4;
    localparam int LANES = 4;
    localparam int REGS = 8;
    localparam int DATA_W = 32;
    localparam int PC_W = 5;
    localparam int WARP_W = $clog2(WARPS);
    localparam int REG_W = $clog2(REGS);
    localparam int ADDR_W = WARP_W + PC_W;
    localparam int INSTR_W = 16;
    localparam int IMM_W = 6;

    // Slots held by the instruction memory and the result sink
    localparam int FETCH_CREDITS = 4;
    localparam int RESULT_CREDITS = 2;

    typedef logic [WARP_W-1:0] warp_idx_t;
    typedef logic [REG_W-1:0] reg_idx_t;
    typedef logic [PC_W-1:0] pc_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_XOR   = 4'h3,
        OP_ADDI  = 4'h4,
        OP_TID   = 4'h5,
        OP_BNZ   = 4'h6,
        OP_STORE = 4'h7,
        OP_HALT  = 4'hf
    } opcode_t;

    // For ADDI and BNZ the low six bits {rs2, pad} hold a signed immediate
    typedef struct packed {
        opcode_t                          opcode;
        reg_idx_t                         rd;
        reg_idx_t                         rs1;
        reg_idx_t                         rs2;
        logic [INSTR_W-4-3*REG_W-1:0]     pad;
    } instr_t;

    typedef struct packed {
        warp_idx_t warp;
        addr_t     addr;
    } ifetch_req_t;

    typedef struct packed {
        warp_idx_t warp;
        instr_t    instr;
    } ifetch_rsp_t;

    // Lane 0 sits in the lowest data word
    typedef struct packed {
        warp_idx_t               warp;
        reg_idx_t                src;
        data_t [LANES-1:0]       data;
    } result_t;

    typedef struct packed {
        logic      we;
        opcode_t   op;
        warp_idx_t warp;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        data_t     imm;
    } lane_op_t;

    typedef enum logic [1:0] {
        WS_IDLE,
        WS_FETCH,
        WS_READY,
        WS_DONE
    } warp_status_t;

endpackage
